// ==== verilog/isa_pkg.sv ====
package isa_pkg;

  // Architectural register file shape
  localparam int REG_IDX_W = 5;
  localparam int REG_COUNT = 32;

  // Register 31 always reads as zero and is never renamed
  localparam logic [REG_IDX_W-1:0] XZR = REG_IDX_W'(31);

  // Integer operations handled by the single ALU
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_ORR  = 3'd3,
    OP_MOVZ = 3'd4,
    OP_ADDS = 3'd5,
    OP_SUBS = 3'd6
  } fu_op_t;

  // Condition flags in ARM order
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // Only the S forms write NZCV
  function automatic logic op_sets_flags(fu_op_t op);
    return (op == OP_ADDS) || (op == OP_SUBS);
  endfunction

endpackage

// ==== verilog/uarch_pkg.sv ====
package uarch_pkg;

  // Life cycle of one reorder buffer slot
  // Slot holds no instruction
  // Instruction allocated, operands or result still pending
  // Result written back, waiting to retire in order
  typedef enum logic [1:0] {
    ROB_FREE = 2'd0,
    ROB_WAIT = 2'd1,
    ROB_DONE = 2'd2
  } rob_state_t;

endpackage

// ==== verilog/rename_regfile.sv ====
module rename_regfile #(
  parameter int XLEN = 64,
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                          in_clk,
  input  logic                          rst,
  input  logic                          dispatch_valid,
  input  isa_pkg::fu_op_t               dispatch_op,
  input  logic [isa_pkg::REG_IDX_W-1:0] dispatch_dst,
  input  logic [isa_pkg::REG_IDX_W-1:0] dispatch_src1,
  input  logic [isa_pkg::REG_IDX_W-1:0] dispatch_src2,
  input  logic [XLEN-1:0]               dispatch_imm,
  input  logic                          dispatch_use_imm,
  input  logic [TAG_W-1:0]              alloc_tag,
  input  logic                          commit_valid,
  input  logic [TAG_W-1:0]              commit_tag,
  input  logic [isa_pkg::REG_IDX_W-1:0] commit_dst,
  input  logic [XLEN-1:0]               commit_value,
  input  logic                          commit_sets_flags,
  input  isa_pkg::nzcv_t                commit_flags,
  output logic                          rename_valid,
  output isa_pkg::fu_op_t               rename_op,
  output logic [isa_pkg::REG_IDX_W-1:0] rename_dst,
  output logic                          rename_sets_flags,
  output logic                          rename_src1_ready,
  output logic [XLEN-1:0]               rename_src1_value,
  output logic [TAG_W-1:0]              rename_src1_tag,
  output logic                          rename_src2_ready,
  output logic [XLEN-1:0]               rename_src2_value,
  output logic [TAG_W-1:0]              rename_src2_tag,
  output logic                          rename_flags_ready,
  output logic [TAG_W-1:0]              rename_flags_tag,
  output isa_pkg::nzcv_t                rename_flags_value
);
  import isa_pkg::*;

  // Per-register rename state, sized by the ROB depth
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } reg_state_t;

  reg_state_t           reg_state [REG_COUNT];
  logic [XLEN-1:0]      reg_value [REG_COUNT];
  logic                 flags_valid;
  logic [TAG_W-1:0]     flags_tag;
  nzcv_t                flags_value;

  // Dispatched fields held for the rename cycle
  logic                 d_valid;
  fu_op_t               d_op;
  logic [REG_IDX_W-1:0] d_dst;
  logic [REG_IDX_W-1:0] d_src1;
  logic [REG_IDX_W-1:0] d_src2;
  logic [XLEN-1:0]      d_imm;
  logic                 d_use_imm;

  always_ff @(posedge in_clk) begin
    if (rst) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= dispatch_valid;
    end
    if (dispatch_valid) begin
      d_op      <= dispatch_op;
      d_dst     <= dispatch_dst;
      d_src1    <= dispatch_src1;
      d_src2    <= dispatch_src2;
      d_imm     <= dispatch_imm;
      d_use_imm <= dispatch_use_imm;
    end
  end

  always_ff @(posedge in_clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        reg_state[i] <= '{valid: 1'b1, tag: '0};
        reg_value[i] <= '0;
      end
      flags_valid <= 1'b1;
      flags_tag   <= '0;
      flags_value <= '0;
    end else begin
      // Only the tag that still owns a register may write it back
      if (commit_valid && (commit_dst != XZR) &&
          (commit_tag == reg_state[commit_dst].tag)) begin
        reg_value[commit_dst]       <= commit_value;
        reg_state[commit_dst].valid <= 1'b1;
      end
      if (commit_valid && commit_sets_flags && (commit_tag == flags_tag)) begin
        flags_value <= commit_flags;
        flags_valid <= 1'b1;
      end
      // A rename at the same edge takes priority over the commit above
      if (d_valid && (d_dst != XZR)) begin
        reg_state[d_dst] <= '{valid: 1'b0, tag: alloc_tag};
      end
      if (d_valid && rename_sets_flags) begin
        flags_valid <= 1'b0;
        flags_tag   <= alloc_tag;
      end
    end
  end

  assign rename_valid      = d_valid;
  assign rename_op         = d_op;
  assign rename_dst        = d_dst;
  assign rename_sets_flags = op_sets_flags(d_op);

  // Sources are read before this instruction's own rename lands,
  // so a source naming the destination sees the older tag
  always_comb begin
    rename_src1_tag = reg_state[d_src1].tag;
    if ((d_src1 == XZR) || (d_op == OP_MOVZ)) begin
      rename_src1_ready = 1'b1;
      rename_src1_value = '0;
    end else begin
      rename_src1_ready = reg_state[d_src1].valid;
      rename_src1_value = reg_value[d_src1];
    end

    rename_src2_tag = reg_state[d_src2].tag;
    if (d_use_imm) begin
      rename_src2_ready = 1'b1;
      rename_src2_value = d_imm;
    end else if (d_src2 == XZR) begin
      rename_src2_ready = 1'b1;
      rename_src2_value = '0;
    end else begin
      rename_src2_ready = reg_state[d_src2].valid;
      rename_src2_value = reg_value[d_src2];
    end

    rename_flags_ready = flags_valid;
    rename_flags_tag   = flags_tag;
    rename_flags_value = flags_value;
  end

endmodule

// ==== verilog/reorder_buffer.sv ====
module reorder_buffer #(
  parameter int XLEN = 64,
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                          in_clk,
  input  logic                          rst,
  input  logic                          rename_valid,
  input  isa_pkg::fu_op_t               rename_op,
  input  logic [isa_pkg::REG_IDX_W-1:0] rename_dst,
  input  logic                          rename_sets_flags,
  input  logic                          rename_src1_ready,
  input  logic [XLEN-1:0]               rename_src1_value,
  input  logic [TAG_W-1:0]              rename_src1_tag,
  input  logic                          rename_src2_ready,
  input  logic [XLEN-1:0]               rename_src2_value,
  input  logic [TAG_W-1:0]              rename_src2_tag,
  input  logic                          rename_flags_ready,
  input  logic [TAG_W-1:0]              rename_flags_tag,
  input  isa_pkg::nzcv_t                rename_flags_value,
  input  logic                          result_valid,
  input  logic [TAG_W-1:0]              result_tag,
  input  logic [XLEN-1:0]               result_value,
  input  isa_pkg::nzcv_t                result_flags,
  output logic [TAG_W-1:0]              alloc_tag,
  output logic                          dispatch_ready,
  output logic                          issue_valid,
  output logic [TAG_W-1:0]              issue_tag,
  output isa_pkg::fu_op_t               issue_op,
  output logic [XLEN-1:0]               issue_a,
  output logic [XLEN-1:0]               issue_b,
  output isa_pkg::nzcv_t                issue_flags_in,
  output logic                          commit_valid,
  output logic [TAG_W-1:0]              commit_tag,
  output logic [isa_pkg::REG_IDX_W-1:0] commit_dst,
  output logic [XLEN-1:0]               commit_value,
  output logic                          commit_sets_flags,
  output isa_pkg::nzcv_t                commit_flags
);
  import isa_pkg::*;
  import uarch_pkg::*;

  rob_state_t           state      [ROB_DEPTH];
  logic                 issued     [ROB_DEPTH];
  fu_op_t               op         [ROB_DEPTH];
  logic [REG_IDX_W-1:0] dst        [ROB_DEPTH];
  logic                 sets_flags [ROB_DEPTH];
  logic [XLEN-1:0]      a_val      [ROB_DEPTH];
  logic                 a_rdy      [ROB_DEPTH];
  logic [TAG_W-1:0]     a_tag      [ROB_DEPTH];
  logic [XLEN-1:0]      b_val      [ROB_DEPTH];
  logic                 b_rdy      [ROB_DEPTH];
  logic [TAG_W-1:0]     b_tag      [ROB_DEPTH];
  nzcv_t                f_val      [ROB_DEPTH];
  logic                 f_rdy      [ROB_DEPTH];
  logic [TAG_W-1:0]     f_tag      [ROB_DEPTH];
  logic [XLEN-1:0]      result     [ROB_DEPTH];
  nzcv_t                res_flags  [ROB_DEPTH];

  logic [TAG_W-1:0]     head;
  logic [TAG_W-1:0]     tail;
  logic [TAG_W:0]       count;

  // Ready bit on top, operand value below
  logic [XLEN:0]        alloc_a;
  logic [XLEN:0]        alloc_b;
  logic                 alloc_f_rdy;
  nzcv_t                alloc_f_val;

  // A pending source may already be done, or may be on the result bus right now
  function automatic logic [XLEN:0] resolve(logic rdy, logic [XLEN-1:0] val,
                                            logic [TAG_W-1:0] tag);
    logic [XLEN:0] res;
    if (rdy) begin
      res = {1'b1, val};
    end else if (state[tag] == ROB_DONE) begin
      res = {1'b1, result[tag]};
    end else if (result_valid && (result_tag == tag)) begin
      res = {1'b1, result_value};
    end else begin
      res = {1'b0, val};
    end
    return res;
  endfunction

  always_comb begin
    alloc_a = resolve(rename_src1_ready, rename_src1_value, rename_src1_tag);
    alloc_b = resolve(rename_src2_ready, rename_src2_value, rename_src2_tag);
    alloc_f_rdy = 1'b1;
    if (rename_flags_ready) begin
      alloc_f_val = rename_flags_value;
    end else if (state[rename_flags_tag] == ROB_DONE) begin
      alloc_f_val = res_flags[rename_flags_tag];
    end else if (result_valid && (result_tag == rename_flags_tag)) begin
      alloc_f_val = result_flags;
    end else begin
      alloc_f_val = rename_flags_value;
      alloc_f_rdy = 1'b0;
    end
  end

  // Oldest waiting entry with all operands in hand
  always_comb begin
    logic [TAG_W-1:0] idx;
    issue_valid = 1'b0;
    issue_tag   = head;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      idx = head + TAG_W'(i);
      if (!issue_valid && (state[idx] == ROB_WAIT) && !issued[idx] &&
          a_rdy[idx] && b_rdy[idx] && f_rdy[idx]) begin
        issue_valid = 1'b1;
        issue_tag   = idx;
      end
    end
  end

  assign issue_op       = op[issue_tag];
  assign issue_a        = a_val[issue_tag];
  assign issue_b        = b_val[issue_tag];
  assign issue_flags_in = f_val[issue_tag];

  assign commit_valid      = (state[head] == ROB_DONE);
  assign commit_tag        = head;
  assign commit_dst        = dst[head];
  assign commit_value      = result[head];
  assign commit_sets_flags = sets_flags[head];
  assign commit_flags      = res_flags[head];

  assign alloc_tag = tail;
  // Leaves room for the instruction still in the rename stage
  assign dispatch_ready = (count < (TAG_W + 1)'(ROB_DEPTH - 1));

  always_ff @(posedge in_clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        state[i]  <= ROB_FREE;
        issued[i] <= 1'b0;
      end
    end else begin
      if (result_valid) begin
        // Wake waiting operands
        for (int i = 0; i < ROB_DEPTH; i++) begin
          if (state[i] == ROB_WAIT) begin
            if (!a_rdy[i] && (a_tag[i] == result_tag)) begin
              a_val[i] <= result_value;
              a_rdy[i] <= 1'b1;
            end
            if (!b_rdy[i] && (b_tag[i] == result_tag)) begin
              b_val[i] <= result_value;
              b_rdy[i] <= 1'b1;
            end
            if (!f_rdy[i] && (f_tag[i] == result_tag)) begin
              f_val[i] <= result_flags;
              f_rdy[i] <= 1'b1;
            end
          end
        end
        state[result_tag]     <= ROB_DONE;
        result[result_tag]    <= result_value;
        res_flags[result_tag] <= result_flags;
      end

      if (issue_valid) begin
        issued[issue_tag] <= 1'b1;
      end

      if (commit_valid) begin
        state[head] <= ROB_FREE;
        head        <= head + TAG_W'(1);
      end

      if (rename_valid) begin
        state[tail]      <= ROB_WAIT;
        issued[tail]     <= 1'b0;
        op[tail]         <= rename_op;
        dst[tail]        <= rename_dst;
        sets_flags[tail] <= rename_sets_flags;
        a_rdy[tail]      <= alloc_a[XLEN];
        a_val[tail]      <= alloc_a[XLEN-1:0];
        a_tag[tail]      <= rename_src1_tag;
        b_rdy[tail]      <= alloc_b[XLEN];
        b_val[tail]      <= alloc_b[XLEN-1:0];
        b_tag[tail]      <= rename_src2_tag;
        f_rdy[tail]      <= alloc_f_rdy;
        f_val[tail]      <= alloc_f_val;
        f_tag[tail]      <= rename_flags_tag;
        tail             <= tail + TAG_W'(1);
      end

      count <= count + (TAG_W + 1)'(rename_valid) - (TAG_W + 1)'(commit_valid);
    end
  end

endmodule

// ==== verilog/int_alu.sv ====
module int_alu #(
  parameter int XLEN = 64,
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic             in_clk,
  input  logic             rst,
  input  logic             issue_valid,
  input  logic [TAG_W-1:0] issue_tag,
  input  isa_pkg::fu_op_t  issue_op,
  input  logic [XLEN-1:0]  issue_a,
  input  logic [XLEN-1:0]  issue_b,
  input  isa_pkg::nzcv_t   issue_flags_in,
  output logic             result_valid,
  output logic [TAG_W-1:0] result_tag,
  output logic [XLEN-1:0]  result_value,
  output isa_pkg::nzcv_t   result_flags
);
  import isa_pkg::*;

  logic [XLEN:0]   sum;
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] alu_value;
  nzcv_t           alu_flags;

  assign sum = {1'b0, issue_a} + {1'b0, issue_b};
  // a + ~b + 1, so the top bit is ARM's carry, set when no borrow occurs
  assign diff = {1'b0, issue_a} + {1'b0, ~issue_b} + (XLEN + 1)'(1);

  always_comb begin
    case (issue_op)
      OP_ADD, OP_ADDS: alu_value = sum[XLEN-1:0];
      OP_SUB, OP_SUBS: alu_value = diff[XLEN-1:0];
      OP_AND:          alu_value = issue_a & issue_b;
      OP_ORR:          alu_value = issue_a | issue_b;
      OP_MOVZ:         alu_value = issue_b;
      default:         alu_value = '0;
    endcase

    alu_flags = issue_flags_in;
    if (issue_op == OP_ADDS) begin
      alu_flags.n = sum[XLEN-1];
      alu_flags.z = (sum[XLEN-1:0] == '0);
      alu_flags.c = sum[XLEN];
      // Same-sign operands giving an opposite-sign sum
      alu_flags.v = (issue_a[XLEN-1] == issue_b[XLEN-1]) &&
                    (sum[XLEN-1] != issue_a[XLEN-1]);
    end else if (issue_op == OP_SUBS) begin
      alu_flags.n = diff[XLEN-1];
      alu_flags.z = (diff[XLEN-1:0] == '0);
      alu_flags.c = diff[XLEN];
      alu_flags.v = (issue_a[XLEN-1] != issue_b[XLEN-1]) &&
                    (diff[XLEN-1] != issue_a[XLEN-1]);
    end
  end

  always_ff @(posedge in_clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid;
    end
    result_tag   <= issue_tag;
    result_value <= alu_value;
    result_flags <= alu_flags;
  end

endmodule

// ==== verilog/rename_core_top.sv ====
module rename_core_top #(
  parameter int XLEN = 64,
  parameter int ROB_DEPTH = 8
) (
  input  logic                          in_clk,
  input  logic                          rst,
  input  logic                          dispatch_valid,
  input  isa_pkg::fu_op_t               dispatch_op,
  input  logic [isa_pkg::REG_IDX_W-1:0] dispatch_dst,
  input  logic [isa_pkg::REG_IDX_W-1:0] dispatch_src1,
  input  logic [isa_pkg::REG_IDX_W-1:0] dispatch_src2,
  input  logic [XLEN-1:0]               dispatch_imm,
  input  logic                          dispatch_use_imm,
  output logic                          dispatch_ready,
  output logic                          commit_valid,
  output logic [isa_pkg::REG_IDX_W-1:0] commit_dst,
  output logic [XLEN-1:0]               commit_value,
  output logic                          commit_sets_flags,
  output isa_pkg::nzcv_t                commit_flags
);
  import isa_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  // Register file to ROB
  logic                 rename_valid;
  fu_op_t               rename_op;
  logic [REG_IDX_W-1:0] rename_dst;
  logic                 rename_sets_flags;
  logic                 rename_src1_ready;
  logic [XLEN-1:0]      rename_src1_value;
  logic [TAG_W-1:0]     rename_src1_tag;
  logic                 rename_src2_ready;
  logic [XLEN-1:0]      rename_src2_value;
  logic [TAG_W-1:0]     rename_src2_tag;
  logic                 rename_flags_ready;
  logic [TAG_W-1:0]     rename_flags_tag;
  nzcv_t                rename_flags_value;

  // ROB to register file
  logic [TAG_W-1:0]     alloc_tag;
  logic [TAG_W-1:0]     commit_tag;

  // ROB and ALU
  logic                 issue_valid;
  logic [TAG_W-1:0]     issue_tag;
  fu_op_t               issue_op;
  logic [XLEN-1:0]      issue_a;
  logic [XLEN-1:0]      issue_b;
  nzcv_t                issue_flags_in;
  logic                 result_valid;
  logic [TAG_W-1:0]     result_tag;
  logic [XLEN-1:0]      result_value;
  nzcv_t                result_flags;

  rename_regfile #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)) regfile0 (.*);

  reorder_buffer #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)) rob0 (.*);

  int_alu #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)) alu0 (.*);

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Waits for room in the ROB, then holds one instruction for a single cycle
task automatic send_instr(input fu_op_t op, input logic [REG_IDX_W-1:0] dst,
                          input logic [REG_IDX_W-1:0] src1, input logic [REG_IDX_W-1:0] src2,
                          input logic [XLEN-1:0] imm, input logic use_imm);
  int waited;
  waited = 0;
  while (!dispatch_ready && !timed_out) begin
    ready_fell = 1'b1;
    @(negedge in_clk);
    waited++;
    if (waited > READY_TIMEOUT) begin
      $display("timeout: dispatch_ready stayed low too long in test %s", cur_test);
      timed_out = 1'b1;
    end
  end
  if (!timed_out) begin
    dispatch_valid   = 1'b1;
    dispatch_op      = op;
    dispatch_dst     = dst;
    dispatch_src1    = src1;
    dispatch_src2    = src2;
    dispatch_imm     = imm;
    dispatch_use_imm = use_imm;
    model_execute(op, dst, src1, src2, imm, use_imm);
    @(negedge in_clk);
    dispatch_valid = 1'b0;
  end
endtask

// Register-register form
task automatic alu_op(input fu_op_t op, input logic [REG_IDX_W-1:0] dst,
                      input logic [REG_IDX_W-1:0] src1, input logic [REG_IDX_W-1:0] src2);
  send_instr(op, dst, src1, src2, '0, 1'b0);
endtask

task automatic load_imm(input logic [REG_IDX_W-1:0] dst, input logic [XLEN-1:0] imm);
  send_instr(OP_MOVZ, dst, XZR, XZR, imm, 1'b1);
endtask

// Runs until every expected commit has been seen
task automatic wait_drain();
  int waited;
  waited = 0;
  while ((expected.size() != 0) && !timed_out) begin
    @(negedge in_clk);
    waited++;
    if (waited > DRAIN_TIMEOUT) begin
      $display("timeout: %0d commits never arrived in test %s", expected.size(), cur_test);
      timed_out = 1'b1;
    end
  end
endtask

task automatic compare_dst(input logic [REG_IDX_W-1:0] exp, input logic [REG_IDX_W-1:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("FAILED %s commit_dst: expected %0d actual %0d", cur_test, exp, act);
  end
endtask

task automatic compare_value(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("FAILED %s commit_value: expected %h actual %h", cur_test, exp, act);
  end
endtask

task automatic compare_bit(input logic exp, input logic act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("FAILED %s commit_sets_flags: expected %b actual %b", cur_test, exp, act);
  end
endtask

task automatic compare_flags(input nzcv_t exp, input nzcv_t act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("FAILED %s commit_flags nzcv: expected %b actual %b", cur_test, exp, act);
  end
endtask

`endif

// ==== testbench/tb_rename_core.sv ====
module tb_rename_core;
  import isa_pkg::*;

  localparam int XLEN = 64;
  localparam int ROB_DEPTH = 8;
  localparam int READY_TIMEOUT = 64;
  localparam int DRAIN_TIMEOUT = 256;

  // One expected commit, in program order
  typedef struct packed {
    logic [REG_IDX_W-1:0] dst;
    logic [XLEN-1:0]      value;
    logic                 sets_flags;
    nzcv_t                flags;
  } expect_t;

  logic                 in_clk;
  logic                 rst;
  logic                 dispatch_valid;
  fu_op_t               dispatch_op;
  logic [REG_IDX_W-1:0] dispatch_dst;
  logic [REG_IDX_W-1:0] dispatch_src1;
  logic [REG_IDX_W-1:0] dispatch_src2;
  logic [XLEN-1:0]      dispatch_imm;
  logic                 dispatch_use_imm;
  logic                 dispatch_ready;
  logic                 commit_valid;
  logic [REG_IDX_W-1:0] commit_dst;
  logic [XLEN-1:0]      commit_value;
  logic                 commit_sets_flags;
  nzcv_t                commit_flags;

  // Sequential model state
  logic [XLEN-1:0] model_regs [REG_COUNT];
  nzcv_t           model_flags;
  expect_t         expected [$];

  string cur_test;
  int    errors;
  int    checks;
  int    tests_run;
  int    test_mark;
  logic  timed_out;
  logic  ready_fell;

  rename_core_top #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)) dut0 (.*);

  initial begin
    in_clk = 1'b0;
    forever #2 in_clk = ~in_clk;
  end

  function automatic logic [XLEN-1:0] read_reg(input logic [REG_IDX_W-1:0] idx);
    return (idx == XZR) ? '0 : model_regs[idx];
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // Executes one instruction in order and queues its commit
  function automatic void model_execute(input fu_op_t op, input logic [REG_IDX_W-1:0] dst,
                                        input logic [REG_IDX_W-1:0] src1,
                                        input logic [REG_IDX_W-1:0] src2,
                                        input logic [XLEN-1:0] imm, input logic use_imm);
    logic [XLEN-1:0]     a;
    logic [XLEN-1:0]     b;
    logic signed [XLEN:0] exact;
    expect_t             e;
    a = read_reg(src1);
    b = use_imm ? imm : read_reg(src2);
    exact = '0;
    e.dst = dst;
    e.sets_flags = (op == OP_ADDS) || (op == OP_SUBS);
    e.flags = model_flags;
    case (op)
      OP_ADD, OP_ADDS: e.value = a + b;
      OP_SUB, OP_SUBS: e.value = a - b;
      OP_AND:          e.value = a & b;
      OP_ORR:          e.value = a | b;
      default:         e.value = b;
    endcase
    if (op == OP_ADDS) begin
      exact = $signed({a[XLEN-1], a}) + $signed({b[XLEN-1], b});
      // Unsigned wrap-around means a carry out
      e.flags.c = (e.value < a);
    end else if (op == OP_SUBS) begin
      exact = $signed({a[XLEN-1], a}) - $signed({b[XLEN-1], b});
      // Carry means no borrow
      e.flags.c = (a >= b);
    end
    if (e.sets_flags) begin
      e.flags.n = e.value[XLEN-1];
      e.flags.z = (e.value == '0);
      e.flags.v = (exact[XLEN] != exact[XLEN-1]);
      model_flags = e.flags;
    end
    if (dst != XZR) begin
      model_regs[dst] = e.value;
    end
    expected.push_back(e);
  endfunction

`include "tb_checks.svh"

  task automatic watch_commits();
    expect_t e;
    forever begin
      @(negedge in_clk);
      if (commit_valid) begin
        if (expected.size() == 0) begin
          errors++;
          $display("commit to x%0d in test %s with nothing outstanding", commit_dst, cur_test);
        end else begin
          e = expected.pop_front();
          compare_dst(e.dst, commit_dst);
          compare_value(e.value, commit_value);
          compare_bit(e.sets_flags, commit_sets_flags);
          if (e.sets_flags) begin
            compare_flags(e.flags, commit_flags);
          end
        end
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_mark = errors;
    tests_run++;
  endtask

  task automatic end_test();
    wait_drain();
    if (timed_out) begin
      $display("test %s: stopped by timeout", cur_test);
    end else if (errors == test_mark) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_mark);
    end
  endtask

  task automatic after_reset_test();
    start_test("after_reset");
    if (!dispatch_ready) begin
      errors++;
      $display("dispatch_ready is low right after reset");
    end
    repeat (8) begin
      @(negedge in_clk);
      if (commit_valid) begin
        errors++;
        $display("commit_valid went high with nothing dispatched");
      end
    end
    alu_op(OP_ADD, 5'd1, 5'd2, 5'd3);
    end_test();
  endtask

  task automatic movz_alu_test();
    start_test("movz_alu");
    for (int i = 0; i < 6; i++) begin
      load_imm(REG_IDX_W'(i), XLEN'($urandom_range(0, 16'hffff)));
    end
    alu_op(OP_ADD, 5'd6, 5'd0, 5'd1);
    alu_op(OP_SUB, 5'd7, 5'd2, 5'd3);
    alu_op(OP_AND, 5'd8, 5'd4, 5'd5);
    alu_op(OP_ORR, 5'd9, 5'd0, 5'd5);
    end_test();
  endtask

  task automatic dependent_chain_test();
    start_test("dependent_chain");
    load_imm(5'd10, rand64());
    // Sources that alias the destination
    alu_op(OP_ADD, 5'd10, 5'd10, 5'd10);
    alu_op(OP_SUB, 5'd11, 5'd10, 5'd1);
    alu_op(OP_ADD, 5'd11, 5'd11, 5'd10);
    alu_op(OP_ORR, 5'd12, 5'd11, 5'd11);
    send_instr(OP_ADD, 5'd10, 5'd10, 5'd0, XLEN'(16'h1234), 1'b1);
    alu_op(OP_AND, 5'd12, 5'd12, 5'd10);
    end_test();
  endtask

  task automatic zero_register_test();
    start_test("zero_register");
    alu_op(OP_ADD, 5'd13, XZR, XZR);
    load_imm(XZR, rand64());
    alu_op(OP_ADD, 5'd14, XZR, 5'd0);
    alu_op(OP_ORR, XZR, 5'd0, 5'd1);
    alu_op(OP_ORR, 5'd15, XZR, XZR);
    alu_op(OP_SUB, 5'd15, 5'd15, XZR);
    end_test();
  endtask

  task automatic flag_case(input fu_op_t op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
    logic [REG_IDX_W-1:0] ra;
    logic [REG_IDX_W-1:0] rb;
    ra = REG_IDX_W'($urandom_range(16, 19));
    rb = REG_IDX_W'($urandom_range(20, 23));
    load_imm(ra, a);
    load_imm(rb, b);
    alu_op(op, REG_IDX_W'($urandom_range(24, 27)), ra, rb);
  endtask

  task automatic flag_ops_test();
    start_test("flag_ops");
    // Overflow, carry with zero, borrow, signed overflow on subtract, equal operands
    flag_case(OP_ADDS, 64'h7fff_ffff_ffff_ffff, 64'd1);
    flag_case(OP_ADDS, '1, 64'd1);
    flag_case(OP_SUBS, 64'd0, 64'd1);
    flag_case(OP_SUBS, 64'h8000_0000_0000_0000, 64'd1);
    flag_case(OP_SUBS, 64'd5, 64'd5);
    repeat (12) begin
      flag_case(($urandom_range(0, 1) != 0) ? OP_ADDS : OP_SUBS, rand64(), rand64());
    end
    end_test();
  endtask

  task automatic backpressure_test();
    start_test("backpressure");
    ready_fell = 1'b0;
    load_imm(5'd20, rand64());
    load_imm(5'd21, rand64());
    // Dependent chain issues every other cycle, so the ROB fills up
    for (int i = 0; i < 20; i++) begin
      if ((i % 4) == 3) begin
        alu_op(OP_SUBS, 5'd20, 5'd20, 5'd21);
      end else begin
        alu_op(OP_ADD, 5'd20, 5'd20, 5'd21);
      end
    end
    if (!ready_fell && !timed_out) begin
      errors++;
      $display("dispatch_ready never fell while the ROB was filling");
    end
    end_test();
  endtask

  initial begin
    void'($urandom(79));
    rst = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op = OP_ADD;
    dispatch_dst = '0;
    dispatch_src1 = '0;
    dispatch_src2 = '0;
    dispatch_imm = '0;
    dispatch_use_imm = 1'b0;
    for (int i = 0; i < REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    model_flags = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    timed_out = 1'b0;
    ready_fell = 1'b0;
    cur_test = "reset";
    repeat (16) @(negedge in_clk);
    rst = 1'b0;
    fork
      watch_commits();
    join_none
    after_reset_test();
    movz_alu_test();
    dependent_chain_test();
    zero_register_test();
    flag_ops_test();
    backpressure_test();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if ((errors == 0) && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+testbench
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/rename_regfile.sv
verilog/reorder_buffer.sv
verilog/int_alu.sv
verilog/rename_core_top.sv
testbench/tb_rename_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the rename core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module tb_rename_core -f compile.f -o tb_rename_core; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_rename_core)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
